/* hw/core_ctrl.sv */
`timescale 1ns/10ps

module core_ctrl (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                fetch_busy_i,
    input  core_pkg::uop_t      dec_uop_i,
    input  logic                exec_redirect_i,
    input  core_pkg::addr_t     exec_target_i,
    input  logic                exec_is_store_i,
    input  logic                store_busy_i,
    input  core_pkg::wb_write_t wb_write_i,
    output logic                stall_fetch_o,
    output logic                stall_dec_o,
    output logic                stall_read_o,
    output logic                stall_exec_o,
    output logic                flush_o,
    output core_pkg::addr_t     redirect_pc_o
);
    import core_pkg::*;

    // One pending bit per register, bit zero stays clear
    logic [31:0] pending_q;
    logic        hazard;
    logic        issue;

    always_comb begin
        hazard = dec_uop_i.valid &&
                 (pending_q[dec_uop_i.rs1] || pending_q[dec_uop_i.rs2]);
    end

    assign stall_exec_o  = exec_is_store_i && store_busy_i;
    assign stall_read_o  = stall_exec_o || hazard;
    assign stall_dec_o   = stall_read_o;
    assign stall_fetch_o = stall_dec_o;

    assign flush_o       = exec_redirect_i;
    assign redirect_pc_o = exec_target_i;

    // Micro-op leaving read with a destination
    assign issue = dec_uop_i.valid && dec_uop_i.writes_rd && !stall_read_o && !flush_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q <= '0;
        end else begin
            if (wb_write_i.valid) begin
                pending_q[wb_write_i.rd] <= 1'b0;
            end
            // A new writer wins over a retiring one
            if (issue && dec_uop_i.rd != '0) begin
                pending_q[dec_uop_i.rd] <= 1'b1;
            end
        end
    end

    // Branches never sit behind a busy store
    assert property (@(posedge clk_i) disable iff (rst_i)
        !(flush_o && stall_exec_o));

    // A redirect never opens a fetch on the same edge
    assert property (@(posedge clk_i) disable iff (rst_i)
        flush_o |=> (!fetch_busy_i || $past(fetch_busy_i)));

endmodule

/* hw/core_pkg.sv */
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;

    localparam addr_t RESET_PC  = 32'h0000_0000;
    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B,
        ALU_BEQ,
        ALU_BNE,
        ALU_JAL,
        ALU_STORE,
        ALU_NONE
    } alu_op_e;

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        addr_t      adr;
        word_t      dat;
        logic [3:0] sel;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        word_t instr;
    } fetch_pkt_t;

    typedef struct packed {
        logic     valid;
        alu_op_e  op;
        addr_t    pc;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    imm;
        logic     use_imm;
        logic     writes_rd;
    } uop_t;

    typedef struct packed {
        uop_t  uop;
        word_t a;
        word_t b;
    } exec_pkt_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } wb_write_t;

    typedef struct packed {
        logic  valid;
        addr_t adr;
        word_t data;
    } store_req_t;

endpackage

/* hw/core_top.sv */
`timescale 1ns/10ps

module core_top (
    input  logic              clk_i,
    input  logic              rst_i,
    output core_pkg::wb_req_t ibus_req_o,
    input  core_pkg::wb_rsp_t ibus_rsp_i,
    output core_pkg::wb_req_t dbus_req_o,
    input  core_pkg::wb_rsp_t dbus_rsp_i
);
    import core_pkg::*;

    logic       stall_fetch;
    logic       stall_dec;
    logic       stall_read;
    logic       stall_exec;
    logic       flush;
    addr_t      redirect_pc;
    logic       fetch_busy;
    logic       exec_redirect;
    addr_t      exec_target;
    logic       exec_is_store;
    logic       store_busy;
    fetch_pkt_t fetch_pkt;
    uop_t       dec_uop;
    exec_pkt_t  exec_pkt;
    wb_write_t  wb_write;
    store_req_t store_req;

    core_ctrl core_ctrl_inst (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .fetch_busy_i    (fetch_busy),
        .dec_uop_i       (dec_uop),
        .exec_redirect_i (exec_redirect),
        .exec_target_i   (exec_target),
        .exec_is_store_i (exec_is_store),
        .store_busy_i    (store_busy),
        .wb_write_i      (wb_write),
        .stall_fetch_o   (stall_fetch),
        .stall_dec_o     (stall_dec),
        .stall_read_o    (stall_read),
        .stall_exec_o    (stall_exec),
        .flush_o         (flush),
        .redirect_pc_o   (redirect_pc)
    );

    fetch_unit fetch_unit_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .stall_i       (stall_fetch),
        .flush_i       (flush),
        .redirect_pc_i (redirect_pc),
        .ibus_req_o    (ibus_req_o),
        .ibus_rsp_i    (ibus_rsp_i),
        .fetch_o       (fetch_pkt),
        .busy_o        (fetch_busy)
    );

    decode_unit decode_unit_inst (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .stall_i (stall_dec),
        .flush_i (flush),
        .fetch_i (fetch_pkt),
        .uop_o   (dec_uop)
    );

    reg_file reg_file_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .stall_i      (stall_read),
        .stall_exec_i (stall_exec),
        .flush_i      (flush),
        .uop_i        (dec_uop),
        .wb_write_i   (wb_write),
        .exec_o       (exec_pkt)
    );

    execute_unit execute_unit_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .stall_i    (stall_exec),
        .exec_i     (exec_pkt),
        .redirect_o (exec_redirect),
        .target_o   (exec_target),
        .is_store_o (exec_is_store),
        .wb_write_o (wb_write),
        .store_o    (store_req)
    );

    store_unit store_unit_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .store_i    (store_req),
        .dbus_req_o (dbus_req_o),
        .dbus_rsp_i (dbus_rsp_i),
        .busy_o     (store_busy)
    );

endmodule

/* hw/decode_unit.sv */
`timescale 1ns/10ps

module decode_unit (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 stall_i,
    input  logic                 flush_i,
    input  core_pkg::fetch_pkt_t fetch_i,
    output core_pkg::uop_t       uop_o
);
    import core_pkg::*;

    word_t      instr;
    logic [6:0] opcode;
    logic [2:0] funct3;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_u;
    uop_t       uop_d;
    uop_t       uop_q;

    assign instr  = fetch_i.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        uop_d           = '0;
        uop_d.valid     = fetch_i.valid;
        uop_d.pc        = fetch_i.pc;
        uop_d.op        = ALU_NONE;
        uop_d.rd        = instr[11:7];
        uop_d.rs1       = instr[19:15];
        uop_d.rs2       = instr[24:20];
        case (opcode)
            OPC_OP_IMM, OPC_OP: begin
                case (funct3)
                    3'b000: uop_d.op = (opcode == OPC_OP && instr[30]) ? ALU_SUB : ALU_ADD;
                    3'b100: uop_d.op = ALU_XOR;
                    3'b110: uop_d.op = ALU_OR;
                    3'b111: uop_d.op = ALU_AND;
                    default: uop_d.op = ALU_NONE;
                endcase
                uop_d.use_imm   = (opcode == OPC_OP_IMM);
                uop_d.imm       = imm_i;
                uop_d.writes_rd = (uop_d.op != ALU_NONE);
                if (opcode == OPC_OP_IMM) begin
                    uop_d.rs2 = '0;
                end
            end
            OPC_LUI: begin
                uop_d.op        = ALU_PASS_B;
                uop_d.imm       = imm_u;
                uop_d.use_imm   = 1'b1;
                uop_d.writes_rd = 1'b1;
                uop_d.rs1       = '0;
                uop_d.rs2       = '0;
            end
            OPC_BRANCH: begin
                if (funct3 == 3'b000) begin
                    uop_d.op = ALU_BEQ;
                end else if (funct3 == 3'b001) begin
                    uop_d.op = ALU_BNE;
                end
                uop_d.imm = imm_b;
            end
            OPC_JAL: begin
                uop_d.op        = ALU_JAL;
                uop_d.imm       = imm_j;
                uop_d.writes_rd = 1'b1;
                uop_d.rs1       = '0;
                uop_d.rs2       = '0;
            end
            OPC_STORE: begin
                uop_d.op  = (funct3 == 3'b010) ? ALU_STORE : ALU_NONE;
                uop_d.imm = imm_s;
            end
            default: begin
                uop_d.rs1 = '0;
                uop_d.rs2 = '0;
            end
        endcase
        // Unsupported encodings read nothing
        if (uop_d.op == ALU_NONE) begin
            uop_d.rs1 = '0;
            uop_d.rs2 = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            uop_q.valid <= 1'b0;
        end else if (!stall_i) begin
            uop_q <= uop_d;
        end
    end

    assign uop_o = uop_q;

endmodule

/* hw/execute_unit.sv */
`timescale 1ns/10ps

module execute_unit (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 stall_i,
    input  core_pkg::exec_pkt_t  exec_i,
    output logic                 redirect_o,
    output core_pkg::addr_t      target_o,
    output logic                 is_store_o,
    output core_pkg::wb_write_t  wb_write_o,
    output core_pkg::store_req_t store_o
);
    import core_pkg::*;

    uop_t       uop;
    word_t      op_b;
    word_t      result;
    logic       taken;
    wb_write_t  wb_q;
    store_req_t st_q;

    assign uop  = exec_i.uop;
    assign op_b = uop.use_imm ? uop.imm : exec_i.b;

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (uop.op)
            ALU_ADD:    result = exec_i.a + op_b;
            ALU_SUB:    result = exec_i.a - op_b;
            ALU_AND:    result = exec_i.a & op_b;
            ALU_OR:     result = exec_i.a | op_b;
            ALU_XOR:    result = exec_i.a ^ op_b;
            ALU_PASS_B: result = op_b;
            ALU_BEQ:    taken  = (exec_i.a == exec_i.b);
            ALU_BNE:    taken  = (exec_i.a != exec_i.b);
            ALU_JAL: begin
                result = uop.pc + 32'd4;
                taken  = 1'b1;
            end
            default:    result = '0;
        endcase
    end

    assign redirect_o = uop.valid && taken;
    assign target_o   = uop.pc + uop.imm;
    assign is_store_o = uop.valid && (uop.op == ALU_STORE);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_q.valid <= 1'b0;
            st_q.valid <= 1'b0;
        end else begin
            wb_q.valid <= uop.valid && uop.writes_rd && !stall_i;
            st_q.valid <= is_store_o && !stall_i;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_q.rd   <= uop.rd;
        wb_q.data <= result;
        if (!stall_i) begin
            st_q.adr  <= exec_i.a + uop.imm;
            st_q.data <= exec_i.b;
        end
    end

    assign wb_write_o = wb_q;
    assign store_o    = st_q;

endmodule

/* hw/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 stall_i,
    input  logic                 flush_i,
    input  core_pkg::addr_t      redirect_pc_i,
    output core_pkg::wb_req_t    ibus_req_o,
    input  core_pkg::wb_rsp_t    ibus_rsp_i,
    output core_pkg::fetch_pkt_t fetch_o,
    output logic                 busy_o
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        DISCARD
    } fetch_state_e;

    fetch_state_e state_q;
    addr_t        pc_q;
    wb_req_t      req_q;
    fetch_pkt_t   pkt_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= IDLE;
            pc_q      <= RESET_PC;
            req_q     <= '0;
            pkt_q     <= '0;
        end else begin
            // Output slot empties once decode takes it
            if (flush_i) begin
                pkt_q.valid <= 1'b0;
                pkt_q.instr <= NOP_INSTR;
            end else if (!stall_i) begin
                pkt_q.valid <= 1'b0;
            end

            case (state_q)
                IDLE: begin
                    if (flush_i) begin
                        pc_q <= redirect_pc_i;
                    end else if (!pkt_q.valid || !stall_i) begin
                        req_q.cyc <= 1'b1;
                        req_q.stb <= 1'b1;
                        req_q.we  <= 1'b0;
                        req_q.adr <= pc_q;
                        req_q.dat <= '0;
                        req_q.sel <= 4'hf;
                        state_q   <= READ;
                    end
                end
                READ: begin
                    if (ibus_rsp_i.ack) begin
                        req_q.cyc <= 1'b0;
                        req_q.stb <= 1'b0;
                        state_q   <= IDLE;
                        if (flush_i) begin
                            pc_q <= redirect_pc_i;
                        end else begin
                            pkt_q <= '{valid: 1'b1, pc: pc_q, instr: ibus_rsp_i.dat};
                            pc_q  <= pc_q + 32'd4;
                        end
                    end else if (flush_i) begin
                        pc_q    <= redirect_pc_i;
                        state_q <= DISCARD;
                    end
                end
                default: begin
                    // Word in flight belongs to the old path
                    if (flush_i) begin
                        pc_q <= redirect_pc_i;
                    end
                    if (ibus_rsp_i.ack) begin
                        req_q.cyc <= 1'b0;
                        req_q.stb <= 1'b0;
                        state_q   <= IDLE;
                    end
                end
            endcase
        end
    end

    assign ibus_req_o = req_q;
    assign fetch_o    = pkt_q;
    assign busy_o     = (state_q != IDLE);

    assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(ibus_req_o.stb) |-> ibus_req_o.cyc);

endmodule

/* hw/reg_file.sv */
`timescale 1ns/10ps

module reg_file (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                stall_i,
    input  logic                stall_exec_i,
    input  logic                flush_i,
    input  core_pkg::uop_t      uop_i,
    input  core_pkg::wb_write_t wb_write_i,
    output core_pkg::exec_pkt_t exec_o
);
    import core_pkg::*;

    word_t     regs_q [1:31];
    word_t     rs1_val;
    word_t     rs2_val;
    exec_pkt_t pkt_q;

    always_ff @(posedge clk_i) begin
        if (wb_write_i.valid && wb_write_i.rd != '0) begin
            regs_q[wb_write_i.rd] <= wb_write_i.data;
        end
    end

    assign rs1_val = (uop_i.rs1 == '0) ? '0 : regs_q[uop_i.rs1];
    assign rs2_val = (uop_i.rs2 == '0) ? '0 : regs_q[uop_i.rs2];

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            pkt_q.uop.valid <= 1'b0;
        end else if (!stall_i) begin
            pkt_q.uop <= uop_i;
            pkt_q.a   <= rs1_val;
            pkt_q.b   <= rs2_val;
        end else if (!stall_exec_i) begin
            // Hazard only, execute moved on so leave a bubble
            pkt_q.uop.valid <= 1'b0;
        end
    end

    assign exec_o = pkt_q;

endmodule

/* hw/store_unit.sv */
`timescale 1ns/10ps

module store_unit (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  core_pkg::store_req_t store_i,
    output core_pkg::wb_req_t    dbus_req_o,
    input  core_pkg::wb_rsp_t    dbus_rsp_i,
    output logic                 busy_o
);
    import core_pkg::*;

    wb_req_t req_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            req_q.cyc <= 1'b0;
            req_q.stb <= 1'b0;
        end else if (req_q.cyc) begin
            if (dbus_rsp_i.ack) begin
                req_q.cyc <= 1'b0;
                req_q.stb <= 1'b0;
            end
        end else if (store_i.valid) begin
            req_q.cyc <= 1'b1;
            req_q.stb <= 1'b1;
        end
    end

    // Address and data only change between transfers
    always_ff @(posedge clk_i) begin
        if (!req_q.cyc && store_i.valid) begin
            req_q.we  <= 1'b1;
            req_q.sel <= 4'hf;
            req_q.adr <= store_i.adr;
            req_q.dat <= store_i.data;
        end
    end

    // Also busy while a request is on its way in
    assign busy_o     = req_q.cyc || store_i.valid;
    assign dbus_req_o = req_q;

    assert property (@(posedge clk_i) disable iff (rst_i)
        store_i.valid |-> !req_q.cyc);

endmodule

/* src.f */
hw/core_pkg.sv
hw/core_ctrl.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/reg_file.sv
hw/execute_unit.sv
hw/store_unit.sv
hw/core_top.sv
verif/core_tb_mem.sv
verif/core_tb.sv

/* verif/core_tb.sv */
`timescale 1ns/10ps

module core_tb;
    import core_pkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 4;
    localparam int MAX_WAIT       = 3;
    localparam int PROG_LEN       = 40;
    localparam int NUM_STORES     = 16;
    localparam int DRAIN_CYCLES   = 40;
    localparam int TIMEOUT_CYCLES = PROG_LEN * 8 * (MAX_WAIT + 1);

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef struct packed {
        addr_t adr;
        word_t data;
    } store_exp_t;

    logic    clk;
    logic    rst;
    wb_req_t ibus_req;
    wb_rsp_t ibus_rsp;
    wb_req_t dbus_req;
    wb_rsp_t dbus_rsp;

    word_t      program_rom [PROG_LEN];
    store_exp_t expected [NUM_STORES];
    int         errors;
    int         stores_seen;

    core_top core_top_inst (
        .clk_i      (clk),
        .rst_i      (rst),
        .ibus_req_o (ibus_req),
        .ibus_rsp_i (ibus_rsp),
        .dbus_req_o (dbus_req),
        .dbus_rsp_i (dbus_rsp)
    );

    core_tb_mem #(.MAX_WAIT(MAX_WAIT)) core_tb_mem_inst (
        .clk_i      (clk),
        .rst_i      (rst),
        .ibus_req_i (ibus_req),
        .ibus_rsp_o (ibus_rsp),
        .dbus_req_i (dbus_req),
        .dbus_rsp_o (dbus_rsp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic word_t imm_alu(input logic [2:0] f3, input reg_idx_t rd,
                                      input reg_idx_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic word_t reg_alu(input logic [6:0] f7, input logic [2:0] f3,
                                      input reg_idx_t rd, input reg_idx_t rs1,
                                      input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t sw_instr(input reg_idx_t rs2, input reg_idx_t rs1,
                                       input logic [11:0] off);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], OPC_STORE};
    endfunction

    function automatic word_t branch_instr(input logic [2:0] f3, input reg_idx_t rs1,
                                           input reg_idx_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t jal_instr(input reg_idx_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic word_t lui_instr(input reg_idx_t rd, input logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    // x1 = 0x123 and x2 = -0xf0 feed most of the ALU checks
    task automatic build_program();
        program_rom[0]  = imm_alu(F3_ADD, 5'd1, 5'd0, 12'h123);
        program_rom[1]  = sw_instr(5'd1, 5'd0, 12'h100);
        program_rom[2]  = imm_alu(F3_ADD, 5'd2, 5'd0, 12'hF10);
        program_rom[3]  = sw_instr(5'd2, 5'd0, 12'h104);
        program_rom[4]  = imm_alu(F3_AND, 5'd3, 5'd1, 12'h0F0);
        program_rom[5]  = sw_instr(5'd3, 5'd0, 12'h108);
        program_rom[6]  = imm_alu(F3_OR, 5'd4, 5'd1, 12'h700);
        program_rom[7]  = sw_instr(5'd4, 5'd0, 12'h10C);
        program_rom[8]  = imm_alu(F3_XOR, 5'd5, 5'd2, 12'h0FF);
        program_rom[9]  = sw_instr(5'd5, 5'd0, 12'h110);
        program_rom[10] = reg_alu(F7_BASE, F3_ADD, 5'd6, 5'd1, 5'd2);
        program_rom[11] = sw_instr(5'd6, 5'd0, 12'h114);
        program_rom[12] = reg_alu(F7_SUB, F3_ADD, 5'd7, 5'd1, 5'd2);
        program_rom[13] = sw_instr(5'd7, 5'd0, 12'h118);
        program_rom[14] = reg_alu(F7_BASE, F3_AND, 5'd8, 5'd1, 5'd2);
        program_rom[15] = sw_instr(5'd8, 5'd0, 12'h11C);
        program_rom[16] = reg_alu(F7_BASE, F3_OR, 5'd9, 5'd1, 5'd2);
        program_rom[17] = sw_instr(5'd9, 5'd0, 12'h120);
        program_rom[18] = reg_alu(F7_BASE, F3_XOR, 5'd10, 5'd1, 5'd2);
        program_rom[19] = sw_instr(5'd10, 5'd0, 12'h124);
        program_rom[20] = lui_instr(5'd11, 20'hABCDE);
        program_rom[21] = sw_instr(5'd11, 5'd0, 12'h128);
        // Back-to-back chain on x12
        program_rom[22] = imm_alu(F3_ADD, 5'd12, 5'd1, 12'h001);
        program_rom[23] = imm_alu(F3_ADD, 5'd12, 5'd12, 12'h001);
        program_rom[24] = reg_alu(F7_BASE, F3_ADD, 5'd12, 5'd12, 5'd12);
        program_rom[25] = sw_instr(5'd12, 5'd0, 12'h12C);
        // Taken branches jump over stores to 0x1f0 and 0x1f4
        program_rom[26] = branch_instr(F3_BEQ, 5'd1, 5'd1, 13'd8);
        program_rom[27] = sw_instr(5'd1, 5'd0, 12'h1F0);
        program_rom[28] = branch_instr(F3_BNE, 5'd1, 5'd2, 13'd8);
        program_rom[29] = sw_instr(5'd2, 5'd0, 12'h1F4);
        program_rom[30] = branch_instr(F3_BEQ, 5'd1, 5'd2, 13'd8);
        program_rom[31] = sw_instr(5'd3, 5'd0, 12'h130);
        program_rom[32] = branch_instr(F3_BNE, 5'd1, 5'd1, 13'd8);
        program_rom[33] = sw_instr(5'd4, 5'd0, 12'h134);
        program_rom[34] = jal_instr(5'd13, 21'd8);
        program_rom[35] = sw_instr(5'd1, 5'd0, 12'h1F8);
        program_rom[36] = sw_instr(5'd13, 5'd0, 12'h138);
        program_rom[37] = imm_alu(F3_ADD, 5'd0, 5'd0, 12'h055);
        program_rom[38] = sw_instr(5'd0, 5'd0, 12'h13C);
        // Spin here
        program_rom[39] = jal_instr(5'd0, 21'd0);
    endtask

    task automatic build_expected();
        expected[0]  = '{adr: 32'h100, data: 32'h0000_0123};
        expected[1]  = '{adr: 32'h104, data: 32'hFFFF_FF10};
        expected[2]  = '{adr: 32'h108, data: 32'h0000_0020};
        expected[3]  = '{adr: 32'h10C, data: 32'h0000_0723};
        expected[4]  = '{adr: 32'h110, data: 32'hFFFF_FFEF};
        expected[5]  = '{adr: 32'h114, data: 32'h0000_0033};
        expected[6]  = '{adr: 32'h118, data: 32'h0000_0213};
        expected[7]  = '{adr: 32'h11C, data: 32'h0000_0100};
        expected[8]  = '{adr: 32'h120, data: 32'hFFFF_FF33};
        expected[9]  = '{adr: 32'h124, data: 32'hFFFF_FE33};
        expected[10] = '{adr: 32'h128, data: 32'hABCD_E000};
        // (0x123 + 2) * 2
        expected[11] = '{adr: 32'h12C, data: 32'h0000_024A};
        expected[12] = '{adr: 32'h130, data: 32'h0000_0020};
        expected[13] = '{adr: 32'h134, data: 32'h0000_0723};
        // Link of the JAL at 0x88
        expected[14] = '{adr: 32'h138, data: 32'h0000_008C};
        expected[15] = '{adr: 32'h13C, data: 32'h0000_0000};
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    function automatic logic store_acked();
        return dbus_req.cyc && dbus_req.stb && dbus_rsp.ack;
    endfunction

    // Sampled on the falling edge, away from the bus updates
    task automatic wait_store(output addr_t adr, output word_t dat);
        do begin
            @(negedge clk);
        end while (!store_acked());
        if (!dbus_req.we || dbus_req.sel != 4'hf) begin
            errors++;
            $display("Data bus transfer at %h is not a full word write", dbus_req.adr);
        end
        adr = dbus_req.adr;
        dat = dbus_req.dat;
    endtask

    // Every instruction fetch is an aligned full word read
    always @(negedge clk) begin
        if (!rst && ibus_req.cyc && ibus_req.stb && ibus_rsp.ack) begin
            if (ibus_req.we || ibus_req.sel != 4'hf || ibus_req.adr[1:0] != 2'b00) begin
                errors++;
                $display("Instruction bus transfer at %h is not an aligned full word read",
                         ibus_req.adr);
            end
        end
    end

    task automatic print_summary();
        $display("Errors: %0d, stores seen: %0d of %0d", errors, stores_seen, NUM_STORES);
    endtask

    initial begin
        addr_t got_adr;
        word_t got_dat;

        void'($urandom(32'h8f26));
        errors      = 0;
        stores_seen = 0;
        rst         = 1'b1;
        build_program();
        build_expected();
        @(posedge clk);
        for (int k = 0; k < PROG_LEN; k++) begin
            core_tb_mem_inst.load_word(k, program_rom[k]);
        end
        repeat (RESET_CYCLES - 1) @(posedge clk);
        rst <= 1'b0;

        for (int n = 0; n < NUM_STORES; n++) begin
            wait_store(got_adr, got_dat);
            check_addr("dbus_req.adr", got_adr, expected[n].adr);
            check_word("dbus_req.dat", got_dat, expected[n].data);
            stores_seen++;
        end

        // Skipped or repeated stores would show up here
        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            if (store_acked()) begin
                errors++;
                $display("Unexpected store to %h after all %0d expected stores",
                         dbus_req.adr, NUM_STORES);
            end
        end

        print_summary();
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        for (int n = stores_seen; n < NUM_STORES; n++) begin
            $display("Store %0d to %h never arrived", n, expected[n].adr);
        end
        errors += NUM_STORES - stores_seen;
        print_summary();
        $display("** FAIL **");
        $finish;
    end

endmodule

/* verif/core_tb_mem.sv */
`timescale 1ns/10ps

module core_tb_mem #(
    parameter int MAX_WAIT = 3
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  core_pkg::wb_req_t ibus_req_i,
    output core_pkg::wb_rsp_t ibus_rsp_o,
    input  core_pkg::wb_req_t dbus_req_i,
    output core_pkg::wb_rsp_t dbus_rsp_o
);
    import core_pkg::*;

    localparam int DEPTH = 64;

    word_t       imem [DEPTH];
    int unsigned iwait;
    int unsigned dwait;

    // Custom-0 opcode, retired by the core as a no-op
    function automatic word_t fill_word(input addr_t adr);
        return {adr[31:7] ^ adr[24:0], 7'b0001011};
    endfunction

    function automatic word_t read_instr(input addr_t adr);
        if (adr[31:8] == '0) begin
            return imem[adr[7:2]];
        end
        return fill_word(adr);
    endfunction

    task automatic load_word(input int idx, input word_t instr);
        imem[idx[5:0]] = instr;
    endtask

    initial begin
        ibus_rsp_o = '0;
        dbus_rsp_o = '0;
        for (int k = 0; k < DEPTH; k++) begin
            imem[k] = fill_word(addr_t'(k * 4));
        end
    end

    // New random wait count for every transfer
    always @(posedge clk_i) begin
        if (rst_i) begin
            ibus_rsp_o <= '0;
            iwait      <= $urandom_range(MAX_WAIT, 0);
        end else if (ibus_rsp_o.ack) begin
            ibus_rsp_o.ack <= 1'b0;
            iwait          <= $urandom_range(MAX_WAIT, 0);
        end else if (ibus_req_i.cyc && ibus_req_i.stb) begin
            if (iwait == 0) begin
                ibus_rsp_o.ack <= 1'b1;
                ibus_rsp_o.dat <= read_instr(ibus_req_i.adr);
            end else begin
                iwait <= iwait - 1;
            end
        end
    end

    always @(posedge clk_i) begin
        if (rst_i) begin
            dbus_rsp_o <= '0;
            dwait      <= $urandom_range(MAX_WAIT, 0);
        end else if (dbus_rsp_o.ack) begin
            dbus_rsp_o.ack <= 1'b0;
            dwait          <= $urandom_range(MAX_WAIT, 0);
        end else if (dbus_req_i.cyc && dbus_req_i.stb) begin
            if (dwait == 0) begin
                dbus_rsp_o.ack <= 1'b1;
            end else begin
                dwait <= dwait - 1;
            end
        end
    end

endmodule
